// File: include/cart_map_consts.svh
`ifndef CART_MAP_CONSTS_SVH
`define CART_MAP_CONSTS_SVH

// Bit positions in the feature vector
`define FEAT_DSPX 0
`define FEAT_SRTC 2
`define FEAT_MSU1 3
`define FEAT_213F 4

// Where each region lives in external memory
`define SAVERAM_BASE      (24'hE00000)
`define MENU_SAVERAM_BASE (24'hFF0000)  // Menu keeps its own save area
`define MENU_ROM_BASE     (24'hC00000)
`define BSX_CARTROM_BASE  (24'h800000)
`define BSX_PSRAM_BASE    (24'h400000)  // 4 Mbit PSRAM

// Cartridge ROM mapped in both halves after reset (regs 7 and 8)
`define BSX_REGS_RESET (15'h0180)

`endif

// File: src/snes_bus_pkg.sv
`default_nettype none

// SNES side of the cartridge edge
package snes_bus_pkg;

  // A-bus address, bank in [23:16]
  typedef logic [23:0] snes_addr_t;

  // B-bus address for $21xx peripherals
  typedef logic [7:0] snes_pa_t;

  typedef logic [7:0] snes_data_t;  // Data bus byte

endpackage

`default_nettype wire

// File: src/cart_map_pkg.sv
`default_nettype none

// Mapping side: configuration and translated addresses
package cart_map_pkg;

  typedef logic [23:0] rom_addr_t;  // External memory address
  typedef logic [23:0] mem_mask_t;  // ROM_MASK / SAVERAM_MASK
  typedef logic [7:0]  feature_t;   // Peripheral enables, see consts header
  typedef logic [14:0] bsx_regs_t;  // BS-X $5000 regs, bit n is register n

  // Mapper codes as detected by the MCU
  typedef enum logic [2:0] {
    HIROM   = 3'd0,
    LOROM   = 3'd1,
    EXHIROM = 3'd2,
    BSX     = 3'd3,
    MENU    = 3'd7
  } mapper_e;

  // MCU configuration register select
  typedef enum logic [1:0] {
    CFG_MAPPER,
    CFG_FEATURES,
    CFG_ROM_MASK,
    CFG_SAVERAM_MASK
  } cfg_sel_e;

endpackage

`default_nettype wire

// File: src/snes_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// Sampled SNES bus, one address per cycle
interface snes_bus_if;

  snes_bus_pkg::snes_addr_t addr;
  snes_bus_pkg::snes_pa_t   pa;
  snes_bus_pkg::snes_data_t data;
  logic                     wr_pulse;  // One cycle per SNES store

  modport source (
    output addr,
    output pa,
    output data,
    output wr_pulse
  );

  modport sink (
    input addr,
    input pa,
    input data,
    input wr_pulse
  );

endinterface

`default_nettype wire

// File: src/map_cfg_if.sv
`timescale 1ns/1ps
`default_nettype none

// Mapper setup from the MCU config block
interface map_cfg_if;

  cart_map_pkg::mapper_e   mapper;
  cart_map_pkg::feature_t  features;
  cart_map_pkg::mem_mask_t rom_mask;
  cart_map_pkg::mem_mask_t saveram_mask;

  modport source (
    output mapper,
    output features,
    output rom_mask,
    output saveram_mask
  );

  modport sink (
    input mapper,
    input features,
    input rom_mask,
    input saveram_mask
  );

endinterface

`default_nettype wire

// File: src/snes_bus_sampler.sv
`timescale 1ns/1ps
`default_nettype none

module snes_bus_sampler (
  input  logic                     CLK,
  input  logic                     rst,
  input  snes_bus_pkg::snes_addr_t snes_addr,
  input  snes_bus_pkg::snes_pa_t   snes_pa,
  input  snes_bus_pkg::snes_data_t snes_data,
  input  logic                     snes_wr,
  snes_bus_if.source               bus
);

  logic wr_level;  // Write level seen at the previous edge

  // All SNES inputs pass one register stage before any decode
  always_ff @(posedge CLK) begin
    if (rst) begin
      bus.addr     <= '0;
      bus.pa       <= '0;
      bus.data     <= '0;
      bus.wr_pulse <= 1'b0;
      wr_level     <= 1'b0;
    end else begin
      bus.addr <= snes_addr;
      bus.pa   <= snes_pa;
      bus.data <= snes_data;
      wr_level <= snes_wr;
      // Rising edge of the write level, aligned with addr and data
      bus.wr_pulse <= snes_wr & ~wr_level;
    end
  end

endmodule

`default_nettype wire

// File: src/cart_config_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cart_config_regs (
  input  logic                    CLK,
  input  logic                    rst,
  input  logic                    cfg_we,
  input  cart_map_pkg::cfg_sel_e  cfg_sel,
  input  cart_map_pkg::mem_mask_t cfg_data,
  map_cfg_if.source               cfg
);

  ////////////////////////////////////////
  // MCU write port
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (rst) begin
      cfg.mapper       <= cart_map_pkg::HIROM;
      cfg.features     <= '0;
      cfg.rom_mask     <= '1;  // Whole memory until header is parsed
      cfg.saveram_mask <= '1;
    end else if (cfg_we) begin
      case (cfg_sel)
        cart_map_pkg::CFG_MAPPER: begin
          cfg.mapper <= cart_map_pkg::mapper_e'(cfg_data[2:0]);
        end
        cart_map_pkg::CFG_FEATURES: begin
          cfg.features <= cfg_data[7:0];
        end
        cart_map_pkg::CFG_ROM_MASK: begin
          cfg.rom_mask <= cfg_data;
        end
        cart_map_pkg::CFG_SAVERAM_MASK: begin
          cfg.saveram_mask <= cfg_data;
        end
        default: begin
          // Nothing else to load
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/bsx_map_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "cart_map_consts.svh"

module bsx_map_regs (
  input  logic                    CLK,
  input  logic                    rst,
  snes_bus_if.sink                bus,
  input  cart_map_pkg::mapper_e   mapper,
  output cart_map_pkg::bsx_regs_t bsx_regs
);

  logic [7:0] bank;
  logic       bank_ok;    // Banks 01-0E
  logic       offset_ok;  // $5000 only
  logic       reg_write;

  assign bank      = bus.addr[23:16];
  assign bank_ok   = (bank[7:4] == 4'h0) && (bank[3:0] != 4'h0) && (bank[3:0] != 4'hF);
  assign offset_ok = (bus.addr[15:0] == 16'h5000);

  // Only the BS-X mapper owns this window
  assign reg_write = bus.wr_pulse && (mapper == cart_map_pkg::BSX) && bank_ok && offset_ok;

  ////////////////////////////////////////
  // Register file, one bit per bank
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (rst) begin
      bsx_regs <= `BSX_REGS_RESET;
    end else if (reg_write) begin
      bsx_regs[bank[3:0]] <= bus.data[7];  // Bank number picks the register
    end
  end

endmodule

`default_nettype wire

// File: src/address_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "cart_map_consts.svh"

module address_decoder (
  input  logic                    CLK,
  input  logic                    rst,
  snes_bus_if.sink                bus,
  map_cfg_if.sink                 cfg,
  input  cart_map_pkg::bsx_regs_t bsx_regs,
  output cart_map_pkg::rom_addr_t rom_addr,
  output logic                    rom_hit,
  output logic                    is_saveram,
  output logic                    is_writable,
  output logic                    msu_enable,
  output logic                    srtc_enable,
  output logic                    dspx_enable,
  output logic                    dspx_a0,
  output logic                    r213f_enable,
  output logic                    snescmd_enable,
  output logic                    bsx_tristate
);

  snes_bus_pkg::snes_addr_t addr;
  snes_bus_pkg::snes_addr_t chk_addr;  // BS-X bank check view
  cart_map_pkg::rom_addr_t  bsx_addr;
  cart_map_pkg::rom_addr_t  rom_addr_d;
  logic                     map_bsx;
  logic                     is_rom;
  logic                     saveram_win;
  logic                     saveram_d;
  logic                     writable_d;
  logic [2:0]               psram_bank;
  logic                     psram_lohi;
  logic                     is_psram;
  logic                     is_cartrom;
  logic                     hole_lohi;
  logic                     is_hole;
  logic                     dspx_en_d;
  logic                     dspx_a0_d;

  assign addr    = bus.addr;
  assign map_bsx = (cfg.mapper == cart_map_pkg::BSX);
  assign is_rom  = addr[22] | addr[15];  // 40-7F full bank, else upper half

  ////////////////////////////////////////
  // Save RAM windows per mapper
  ////////////////////////////////////////

  always_comb begin
    case (cfg.mapper)
      cart_map_pkg::HIROM, cart_map_pkg::EXHIROM, cart_map_pkg::MENU: begin
        // 20-3F / A0-BF : 6000-7FFF
        saveram_win = ~addr[22] & addr[21] & (&addr[14:13]) & ~addr[15];
      end
      cart_map_pkg::LOROM: begin
        // 70-7D / F0-FD, upper half too on small ROMs
        saveram_win = (&addr[22:20]) & (addr[19:16] < 4'hE)
                      & (~addr[15] | ~cfg.rom_mask[21]);
      end
      cart_map_pkg::BSX: begin
        saveram_win = (addr[23:19] == 5'b00010) & (addr[15:12] == 4'b0101);
      end
      default: saveram_win = 1'b0;
    endcase
  end

  assign saveram_d = cfg.saveram_mask[0] & saveram_win;  // Mask 0 means no save RAM

  ////////////////////////////////////////
  // BS-X PSRAM, cartridge ROM and hole
  ////////////////////////////////////////

  assign psram_bank = {bsx_regs[2], bsx_regs[6], bsx_regs[5]};
  assign chk_addr   = bsx_regs[2] ? addr : {addr[23], 1'b0, addr[22:16], addr[14:0]};
  assign psram_lohi = (bsx_regs[3] & ~addr[23]) | (bsx_regs[4] & addr[23]);

  assign is_psram = psram_lohi
                    & (((chk_addr[22:20] == psram_bank)
                        & (addr[15] | bsx_regs[2])
                        & ~(addr[19] & bsx_regs[2]))
                       | (bsx_regs[2] ? ((addr[22:21] == 2'b01) & (addr[15:13] == 3'b011))
                                      : ((&addr[22:20]) & ~addr[15])));

  assign is_cartrom = ((bsx_regs[7] & (addr[23:22] == 2'b00))
                       | (bsx_regs[8] & (addr[23:22] == 2'b10)))
                      & addr[15];

  assign hole_lohi = (bsx_regs[9] & ~addr[23]) | (bsx_regs[10] & addr[23]);
  assign is_hole   = hole_lohi & (bsx_regs[2] ? (addr[21:20] == {bsx_regs[11], 1'b0})
                                              : (addr[22:21] == {bsx_regs[11], 1'b0}));

  // HiROM layout takes the address as is, LoROM drops A15
  assign bsx_addr = bsx_regs[2] ? {1'b0, addr[22:0]} : {2'b00, addr[22:16], addr[14:0]};

  assign writable_d = saveram_d | (map_bsx & is_psram);

  ////////////////////////////////////////
  // Address translation
  ////////////////////////////////////////

  always_comb begin
    case (cfg.mapper)
      cart_map_pkg::HIROM: begin
        rom_addr_d = saveram_d
                     ? `SAVERAM_BASE + ({6'd0, addr[20:16], addr[12:0]} & cfg.saveram_mask)
                     : {1'b0, addr[22:0]} & cfg.rom_mask;
      end
      cart_map_pkg::LOROM: begin
        rom_addr_d = saveram_d
                     ? `SAVERAM_BASE + ({4'd0, addr[20:16], addr[14:0]} & cfg.saveram_mask)
                     : {2'b00, addr[22:16], addr[14:0]} & cfg.rom_mask;
      end
      cart_map_pkg::EXHIROM: begin
        rom_addr_d = saveram_d
                     ? `SAVERAM_BASE + ({6'd0, addr[20:16], addr[12:0]} & cfg.saveram_mask)
                     : {1'b0, ~addr[23], addr[21:0]} & cfg.rom_mask;  // Banks C0+ first
      end
      cart_map_pkg::BSX: begin
        if (saveram_d) begin
          rom_addr_d = `SAVERAM_BASE + {9'd0, addr[18:16], addr[11:0]};
        end else if (is_cartrom) begin
          rom_addr_d = `BSX_CARTROM_BASE + ({2'b00, addr[22:16], addr[14:0]} & 24'h0FFFFF);
        end else if (is_psram) begin
          rom_addr_d = `BSX_PSRAM_BASE + (bsx_addr & 24'h07FFFF);
        end else begin
          rom_addr_d = bsx_addr & 24'h0FFFFF;  // Flash
        end
      end
      cart_map_pkg::MENU: begin
        rom_addr_d = saveram_d
                     ? `MENU_SAVERAM_BASE + ({9'd0, addr[14:0] - 15'h6000} & cfg.saveram_mask)
                     : ({1'b0, addr[22:0]} & cfg.rom_mask) + `MENU_ROM_BASE;
      end
      default: rom_addr_d = '0;
    endcase
  end

  // DSP1 data/status select
  always_comb begin
    dspx_en_d = 1'b0;
    dspx_a0_d = 1'b1;
    if (cfg.features[`FEAT_DSPX]) begin
      if (cfg.mapper == cart_map_pkg::LOROM) begin
        // 60-6F:0000-7FFF on large ROMs, else 30-3F:8000-FFFF
        dspx_en_d = cfg.rom_mask[20] ? (addr[22] & addr[21] & ~addr[20] & ~addr[15])
                                     : (~addr[22] & addr[21] & addr[20] & addr[15]);
        dspx_a0_d = addr[14];
      end else if (cfg.mapper == cart_map_pkg::HIROM) begin
        dspx_en_d = ~addr[22] & ~addr[21] & ~addr[20] & ~addr[15] & (&addr[14:13]);
        dspx_a0_d = addr[12];
      end
    end
  end

  ////////////////////////////////////////
  // Output register stage
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (rst) begin
      rom_hit        <= 1'b0;
      is_saveram     <= 1'b0;
      is_writable    <= 1'b0;
      msu_enable     <= 1'b0;
      srtc_enable    <= 1'b0;
      dspx_enable    <= 1'b0;
      dspx_a0        <= 1'b1;
      r213f_enable   <= 1'b0;
      snescmd_enable <= 1'b0;
      bsx_tristate   <= 1'b0;
    end else begin
      rom_hit      <= is_rom | writable_d;
      is_saveram   <= saveram_d;
      is_writable  <= writable_d;
      msu_enable   <= cfg.features[`FEAT_MSU1] & ~addr[22]
                      & ((addr[15:0] & 16'hFFF8) == 16'h2000);
      srtc_enable  <= cfg.features[`FEAT_SRTC] & ~addr[22]
                      & ((addr[15:0] & 16'hFFFE) == 16'h2800);
      dspx_enable  <= dspx_en_d;
      dspx_a0      <= dspx_a0_d;
      r213f_enable <= cfg.features[`FEAT_213F] & (bus.pa == 8'h3F);
      // Command area, no feature bit
      snescmd_enable <= ({addr[22], addr[15:8]} == 9'b0_0010_1010);
      bsx_tristate   <= map_bsx & ~is_cartrom & ~is_psram & is_hole;
    end
  end

  always_ff @(posedge CLK) begin
    rom_addr <= rom_addr_d;
  end

endmodule

`default_nettype wire

// File: src/cart_map_top.sv
`timescale 1ns/1ps
`default_nettype none

module cart_map_top (
  input  logic                     CLK,
  input  logic                     rst,
  input  snes_bus_pkg::snes_addr_t snes_addr,
  input  snes_bus_pkg::snes_pa_t   snes_pa,
  input  snes_bus_pkg::snes_data_t snes_data,
  input  logic                     snes_wr,
  input  logic                     cfg_we,
  input  cart_map_pkg::cfg_sel_e   cfg_sel,
  input  cart_map_pkg::mem_mask_t  cfg_data,
  output cart_map_pkg::rom_addr_t  rom_addr,
  output logic                     rom_hit,
  output logic                     is_saveram,
  output logic                     is_writable,
  output logic                     msu_enable,
  output logic                     srtc_enable,
  output logic                     dspx_enable,
  output logic                     dspx_a0,
  output logic                     r213f_enable,
  output logic                     snescmd_enable,
  output logic                     bsx_tristate
);

  snes_bus_if bus_if ();
  map_cfg_if  cfg_if ();

  cart_map_pkg::bsx_regs_t bsx_regs;

  ////////////////////////////////////////
  // Bus sampling and configuration
  ////////////////////////////////////////

  snes_bus_sampler u_sampler (
    .CLK       (CLK),
    .rst       (rst),
    .snes_addr (snes_addr),
    .snes_pa   (snes_pa),
    .snes_data (snes_data),
    .snes_wr   (snes_wr),
    .bus       (bus_if.source)
  );

  cart_config_regs u_config (
    .CLK      (CLK),
    .rst      (rst),
    .cfg_we   (cfg_we),
    .cfg_sel  (cfg_sel),
    .cfg_data (cfg_data),
    .cfg      (cfg_if.source)
  );

  bsx_map_regs u_bsx_regs (
    .CLK      (CLK),
    .rst      (rst),
    .bus      (bus_if.sink),
    .mapper   (cfg_if.mapper),  // Register window only live in BS-X mode
    .bsx_regs (bsx_regs)
  );

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  address_decoder u_decoder (
    .CLK            (CLK),
    .rst            (rst),
    .bus            (bus_if.sink),
    .cfg            (cfg_if.sink),
    .bsx_regs       (bsx_regs),
    .rom_addr       (rom_addr),
    .rom_hit        (rom_hit),
    .is_saveram     (is_saveram),
    .is_writable    (is_writable),
    .msu_enable     (msu_enable),
    .srtc_enable    (srtc_enable),
    .dspx_enable    (dspx_enable),
    .dspx_a0        (dspx_a0),
    .r213f_enable   (r213f_enable),
    .snescmd_enable (snescmd_enable),
    .bsx_tristate   (bsx_tristate)
  );

endmodule

`default_nettype wire

// File: verification/cart_map_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "cart_map_consts.svh"

module cart_map_assertions (
  input logic                     CLK,
  input logic                     rst,
  input snes_bus_pkg::snes_addr_t snes_addr,
  input snes_bus_pkg::snes_pa_t   snes_pa,
  input snes_bus_pkg::snes_data_t snes_data,
  input logic                     snes_wr,
  input logic                     cfg_we,
  input cart_map_pkg::cfg_sel_e   cfg_sel,
  input cart_map_pkg::mem_mask_t  cfg_data,
  input cart_map_pkg::rom_addr_t  rom_addr,
  input logic                     rom_hit,
  input logic                     is_saveram,
  input logic                     is_writable,
  input logic                     msu_enable,
  input logic                     srtc_enable,
  input logic                     dspx_enable,
  input logic                     dspx_a0,
  input logic                     r213f_enable,
  input logic                     snescmd_enable,
  input logic                     bsx_tristate
);

  logic                     failed = 1'b0;  // Sticky, any assertion fired
  snes_bus_pkg::snes_addr_t a_q1;
  snes_bus_pkg::snes_addr_t a_q2;           // Address two edges back
  snes_bus_pkg::snes_pa_t   pa_q1;
  snes_bus_pkg::snes_pa_t   pa_q2;
  logic [2:0]               map_m;
  logic [2:0]               map_q1;
  cart_map_pkg::feature_t   feat_m;
  cart_map_pkg::feature_t   feat_q1;
  cart_map_pkg::mem_mask_t  rmask_m;
  cart_map_pkg::mem_mask_t  rmask_q1;
  cart_map_pkg::mem_mask_t  smask_m;
  cart_map_pkg::mem_mask_t  smask_q1;
  cart_map_pkg::bsx_regs_t  bsx_m;
  cart_map_pkg::bsx_regs_t  bsx_q1;
  cart_map_pkg::bsx_regs_t  bsx_q2;
  logic                     wr_m;
  logic [1:0]               live;           // Pipeline filled since reset

  ////////////////////////////////////////
  // Reference model of the loaded state
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    a_q1     <= snes_addr;
    a_q2     <= a_q1;
    pa_q1    <= snes_pa;
    pa_q2    <= pa_q1;
    map_q1   <= map_m;
    feat_q1  <= feat_m;
    rmask_q1 <= rmask_m;
    smask_q1 <= smask_m;
    bsx_q1   <= bsx_m;
    bsx_q2   <= bsx_q1;  // Store lands one edge after its sample
    if (rst) begin
      live    <= 2'b00;
      wr_m    <= 1'b0;
      map_m   <= cart_map_pkg::HIROM;
      feat_m  <= '0;
      rmask_m <= '1;
      smask_m <= '1;
      bsx_m   <= `BSX_REGS_RESET;
    end else begin
      live <= {live[0], 1'b1};
      wr_m <= snes_wr;
      if (cfg_we) begin
        case (cfg_sel)
          cart_map_pkg::CFG_MAPPER:       map_m   <= cfg_data[2:0];
          cart_map_pkg::CFG_FEATURES:     feat_m  <= cfg_data[7:0];
          cart_map_pkg::CFG_ROM_MASK:     rmask_m <= cfg_data;
          cart_map_pkg::CFG_SAVERAM_MASK: smask_m <= cfg_data;
          default: ;
        endcase
      end
      // $5000 in banks 01-0E, bank number picks the bit
      if (snes_wr && !wr_m && map_m == cart_map_pkg::BSX && snes_addr[23:20] == 4'h0
          && snes_addr[19:16] != 4'h0 && snes_addr[19:16] != 4'hF
          && snes_addr[15:0] == 16'h5000) begin
        bsx_m[snes_addr[19:16]] <= snes_data[7];
      end
    end
  end

  ////////////////////////////////////////
  // Mapping rules
  ////////////////////////////////////////

  reset_values: assert property (@(posedge CLK) rst |=> !rom_hit && !is_saveram
      && !is_writable && !msu_enable && !srtc_enable && !dspx_enable && dspx_a0
      && !r213f_enable && !snescmd_enable && !bsx_tristate)
    else begin
      failed = 1'b1;
      $error("outputs not at their reset values");
    end

  hirom_rom: assert property (@(posedge CLK) disable iff (rst)
      live[1] && map_q1 == cart_map_pkg::HIROM && (a_q2[22] || a_q2[15])
      |-> rom_hit && rom_addr == ({1'b0, a_q2[22:0]} & rmask_q1))
    else begin
      failed = 1'b1;
      $error("HiROM ROM address wrong");
    end

  hirom_sram: assert property (@(posedge CLK) disable iff (rst)
      live[1] && map_q1 == cart_map_pkg::HIROM && smask_q1 != '0
      && a_q2[22:21] == 2'b01 && a_q2[15:13] == 3'b011
      |-> is_saveram && rom_addr == `SAVERAM_BASE + ({a_q2[20:16], a_q2[12:0]} & smask_q1))
    else begin
      failed = 1'b1;
      $error("HiROM save RAM address wrong");
    end

  lorom_sram: assert property (@(posedge CLK) disable iff (rst)
      live[1] && map_q1 == cart_map_pkg::LOROM && smask_q1 != '0
      && a_q2[22:20] == 3'b111 && a_q2[19:16] < 4'hE && !a_q2[15]
      |-> is_saveram && rom_addr == `SAVERAM_BASE + ({a_q2[19:16], a_q2[14:0]} & smask_q1))
    else begin
      failed = 1'b1;
      $error("LoROM save RAM address wrong");
    end

  lorom_rom: assert property (@(posedge CLK) disable iff (rst)
      live[1] && map_q1 == cart_map_pkg::LOROM && rmask_q1[21] && a_q2[15]
      |-> rom_hit && rom_addr == ({a_q2[22:16], a_q2[14:0]} & rmask_q1))
    else begin
      failed = 1'b1;
      $error("LoROM ROM address wrong");
    end

  menu_rom: assert property (@(posedge CLK) disable iff (rst)
      live[1] && map_q1 == cart_map_pkg::MENU && a_q2[15]
      |-> rom_hit && rom_addr == ({1'b0, a_q2[22:0]} & rmask_q1) + `MENU_ROM_BASE)
    else begin
      failed = 1'b1;
      $error("menu ROM address wrong");
    end

  // Peripheral windows in banks 00-3F
  feature_windows: assert property (@(posedge CLK) disable iff (rst)
      live[1] && a_q2[23:22] == 2'b00
      |-> msu_enable == (feat_q1[`FEAT_MSU1] && a_q2[15:3] == 13'h0400)
          && srtc_enable == (feat_q1[`FEAT_SRTC] && a_q2[15:1] == 15'h1400)
          && snescmd_enable == (a_q2[15:8] == 8'h2A)
          && (feat_q1[`FEAT_DSPX] || !dspx_enable))
    else begin
      failed = 1'b1;
      $error("peripheral window enable wrong");
    end

  b_bus_213f: assert property (@(posedge CLK) disable iff (rst)
      live[1] |-> r213f_enable == (feat_q1[`FEAT_213F] && pa_q2 == 8'h3F))
    else begin
      failed = 1'b1;
      $error("$213F enable wrong");
    end

  bsx_psram: assert property (@(posedge CLK) disable iff (rst)
      live[1] && map_q1 == cart_map_pkg::BSX && bsx_q2[3] && bsx_q2[2]
      && !bsx_q2[5] && !bsx_q2[6] && a_q2[23:19] == 5'b01000
      |-> is_writable && rom_addr == `BSX_PSRAM_BASE + (a_q2 & 24'h07FFFF))
    else begin
      failed = 1'b1;
      $error("BS-X PSRAM mapping wrong");
    end

  bsx_cartrom: assert property (@(posedge CLK) disable iff (rst)
      live[1] && map_q1 == cart_map_pkg::BSX && a_q2[23:22] == 2'b00 && a_q2[15]
      |-> (bsx_q2[7] ? rom_addr == `BSX_CARTROM_BASE
                                   + ({a_q2[22:16], a_q2[14:0]} & 24'h0FFFFF)
                     : rom_addr < `BSX_CARTROM_BASE))
    else begin
      failed = 1'b1;
      $error("BS-X cartridge ROM mapping wrong");
    end

endmodule

bind cart_map_top cart_map_assertions u_checks (.*);

`default_nettype wire

// File: verification/cart_map_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cart_map_tb;

  localparam int CLK_PERIOD = 8;
  localparam int SWEEPS     = 25;                        // Iterations per phase
  localparam int RUN_CYCLES = 8 + 6 * SWEEPS * 8 + 64;  // Six phases, 8 addresses each

  logic                     CLK;
  logic                     rst;
  snes_bus_pkg::snes_addr_t snes_addr;
  snes_bus_pkg::snes_pa_t   snes_pa;
  snes_bus_pkg::snes_data_t snes_data;
  logic                     snes_wr;
  logic                     cfg_we;
  cart_map_pkg::cfg_sel_e   cfg_sel;
  cart_map_pkg::mem_mask_t  cfg_data;
  cart_map_pkg::rom_addr_t  rom_addr;
  logic                     rom_hit;
  logic                     is_saveram;
  logic                     is_writable;
  logic                     msu_enable;
  logic                     srtc_enable;
  logic                     dspx_enable;
  logic                     dspx_a0;
  logic                     r213f_enable;
  logic                     snescmd_enable;
  logic                     bsx_tristate;

  cart_map_top dut0 (.*);

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic load_cfg(input cart_map_pkg::cfg_sel_e sel, input logic [23:0] value);
    cfg_we   = 1'b1;
    cfg_sel  = sel;
    cfg_data = value;
    next_cycle();
    cfg_we = 1'b0;
  endtask

  function automatic logic [23:0] rand_addr(input logic [7:0] bank_lo, input logic [7:0] bank_hi,
                                            input logic [15:0] off_lo, input logic [15:0] off_hi);
    logic [7:0]  bank;
    logic [15:0] off;
    bank = bank_lo + 8'($urandom % (bank_hi - bank_lo + 1));
    off  = off_lo + 16'($urandom % (off_hi - off_lo + 1));
    return {bank, off};
  endfunction

  task automatic present(input logic [23:0] addr);
    snes_addr = addr;
    snes_pa   = 8'h3E + 8'($urandom % 3);  // Around $213F
    next_cycle();
  endtask

  // SNES store, write level held one cycle
  task automatic snes_store(input logic [23:0] addr, input logic [7:0] data);
    snes_addr = addr;
    snes_data = data;
    snes_wr   = 1'b1;
    next_cycle();
    snes_wr = 1'b0;
    next_cycle();
  endtask

  task automatic sweep();
    repeat (SWEEPS) begin
      present(rand_addr(8'h00, 8'hFF, 16'h0000, 16'hFFFF));
      present(rand_addr(8'h20, 8'h3F, 16'h6000, 16'h7FFF));  // HiROM save RAM
      present(rand_addr(8'h70, 8'h7D, 16'h0000, 16'h7FFF));  // LoROM save RAM
      present(rand_addr(8'h00, 8'h3F, 16'h1FFF, 16'h2008));  // MSU1
      present(rand_addr(8'h00, 8'h3F, 16'h27FF, 16'h2802));
      present(rand_addr(8'h00, 8'h3F, 16'h29FF, 16'h2B00));  // Command area edges
      present(rand_addr(8'h40, 8'h47, 16'h0000, 16'hFFFF));  // BS-X PSRAM banks
      present(rand_addr(8'h00, 8'h3F, 16'h8000, 16'hFFFF));
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    CLK       = 1'b0;
    rst       = 1'b1;
    snes_addr = '0;
    snes_pa   = '0;
    snes_data = '0;
    snes_wr   = 1'b0;
    cfg_we    = 1'b0;
    cfg_sel   = cart_map_pkg::CFG_MAPPER;
    cfg_data  = '0;
    void'($urandom(65100));
    repeat (8) @(posedge CLK);
    #1;
    rst = 1'b0;

    load_cfg(cart_map_pkg::CFG_ROM_MASK, 24'h3FFFFF);
    load_cfg(cart_map_pkg::CFG_SAVERAM_MASK, 24'h001FFF);  // 8 KB save RAM
    load_cfg(cart_map_pkg::CFG_FEATURES, 24'h00001C);      // S-RTC, MSU1, $213F
    sweep();
    load_cfg(cart_map_pkg::CFG_FEATURES, 24'h000000);
    sweep();
    load_cfg(cart_map_pkg::CFG_MAPPER, 24'(cart_map_pkg::LOROM));
    sweep();
    load_cfg(cart_map_pkg::CFG_MAPPER, 24'(cart_map_pkg::MENU));
    sweep();

    load_cfg(cart_map_pkg::CFG_MAPPER, 24'(cart_map_pkg::BSX));
    snes_store(24'h035000, 8'h80);  // PSRAM in low half
    snes_store(24'h025000, 8'h80);  // HiROM layout
    sweep();
    snes_store(24'h075000, 8'h00);  // Drop cartridge ROM, low half
    sweep();

    repeat (3) next_cycle();
    if (dut0.u_checks.failed) begin
      $display("FAILED at %0t ns: DUT output differs from the expected mapping", $time);
      $display("ERRORS FOUND");
      $fatal(1, "mapping check failed");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

  // First assertion failure ends the run
  initial begin
    wait (dut0.u_checks.failed === 1'b1);
    $display("FAILED at %0t ns: DUT output differs from the expected mapping", $time);
    $display("ERRORS FOUND");
    $fatal(1, "mapping check failed");
  end

  initial begin
    #(2 * RUN_CYCLES * CLK_PERIOD);
    $display("Timeout: the stimulus did not finish within %0d cycles", 2 * RUN_CYCLES);
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+include
src/snes_bus_pkg.sv
src/cart_map_pkg.sv
src/snes_bus_if.sv
src/map_cfg_if.sv
src/snes_bus_sampler.sv
src/cart_config_regs.sv
src/bsx_map_regs.sv
src/address_decoder.sv
src/cart_map_top.sv
verification/cart_map_assertions.sv
verification/cart_map_tb.sv
